// ==== spm_params.svh ====
// Sparse polynomial multiplier constants
// ring size, modulus, core count and the widths and depths derived from them

`ifndef SPM_PARAMS_SVH
`define SPM_PARAMS_SVH

// coefficient modulus
`define SPM_Q 251

// ring x^N+1 and nonzero count of the sparse operand
`define SPM_N 64
`define SPM_H 16

// positions handled per outer pass
`define SPM_CORES 2

`define SPM_COEFF_W 8
`define SPM_POS_W 6

// one position word per outer pass, two coefficients per dense word
`define SPM_POS_DEPTH (`SPM_H / `SPM_CORES)
`define SPM_RES_DEPTH (`SPM_N / 2)

`endif

// ==== spm_pkg.sv ====
// Sparse polynomial multiplier types
// vector types for coefficients, packed coefficient pairs, positions
// and memory addresses

`default_nettype none

`include "spm_params.svh"

package spm_pkg;

  // one coefficient mod Q, and the unreduced sum of two
  typedef logic [`SPM_COEFF_W-1:0] coeff_t;
  typedef logic [`SPM_COEFF_W:0] coeff_sum_t;

  // even index in the low half
  typedef logic [2*`SPM_COEFF_W-1:0] coeff_pair_t;

  // position word holds core 0 in the low bits
  typedef logic [`SPM_POS_W-1:0] pos_t;
  typedef logic [`SPM_CORES*`SPM_POS_W-1:0] pos_word_t;

  typedef logic [$clog2(`SPM_POS_DEPTH)-1:0] pos_addr_t;
  typedef logic [$clog2(`SPM_RES_DEPTH)-1:0] word_addr_t;
  typedef logic [$clog2(`SPM_N)-1:0] coeff_idx_t;

endpackage

`default_nettype wire

// ==== spm_dual_ram.sv ====
// Dual-port synchronous RAM
// two independent ports, each with a write enable and a registered
// read output that returns the old contents on a same-address write

`timescale 1ns/100ps
`default_nettype none

module spm_dual_ram #(
  parameter int WIDTH = 16,
  parameter int DEPTH = 32
)
(
  input  wire                       clk,
  input  wire                       wr_en_a,
  input  wire  [$clog2(DEPTH)-1:0]  addr_a,
  input  wire  [WIDTH-1:0]          wr_data_a,
  output logic [WIDTH-1:0]          rd_data_a,
  input  wire                       wr_en_b,
  input  wire  [$clog2(DEPTH)-1:0]  addr_b,
  input  wire  [WIDTH-1:0]          wr_data_b,
  output logic [WIDTH-1:0]          rd_data_b
);

  logic [WIDTH-1:0] mem [DEPTH];

  // both ports in one process so the array has a single writer
  always_ff @(posedge clk)
  begin
    if (wr_en_a)
      mem[addr_a] <= wr_data_a;
    if (wr_en_b)
      mem[addr_b] <= wr_data_b;
    rd_data_a <= mem[addr_a];
    rd_data_b <= mem[addr_b];
  end

endmodule

`default_nettype wire

// ==== spm_ctrl.sv ====
// Sparse multiplier loop control
// runs one outer pass per position word and sweeps all result words in
// each pass; short strobe chains line up the position read, the dense
// reads, the result read-back and the result writes

`timescale 1ns/100ps
`default_nettype none

`include "spm_params.svh"

module spm_ctrl
  import spm_pkg::*;
(
  input  wire             clk,
  input  wire             rst_n,
  input  wire             start,
  output logic            busy,
  output logic            done,
  output pos_addr_t       pos_rd_addr,
  input  wire pos_word_t  pos_rd_data,
  output word_addr_t      poly_rd_addr_0,
  output word_addr_t      poly_rd_addr_1,
  output logic            pos_load,
  output coeff_idx_t      coeff_idx,
  output logic            neg_pass,
  output logic            first_pass,
  output word_addr_t      res_rd_addr_int,
  output word_addr_t      res_wr_addr,
  output logic            res_wr_en
);

  logic       accept;
  logic       pass_go;
  logic       pass_next;
  logic       last_wr;
  logic [1:0] pos_sr;
  logic [1:0] idx_sr;
  logic [3:0] wr_sr;
  word_addr_t inner_cnt;

  // dense word holding coefficient (N - p) mod N
  function automatic word_addr_t start_word(input pos_t p);
    pos_t wrap;
    wrap = pos_t'(`SPM_N - p);
    return wrap[`SPM_POS_W-1:1];
  endfunction

  assign accept     = start & ~busy;
  assign pass_go    = accept | pass_next;
  assign last_wr    = res_wr_en & (res_wr_addr == word_addr_t'(`SPM_RES_DEPTH - 1));
  assign pos_load   = pos_sr[1];
  assign coeff_idx  = {inner_cnt, 1'b0};
  // position memory address doubles as the outer pass counter
  assign first_pass = (pos_rd_addr == '0);
  assign neg_pass   = (pos_rd_addr >= pos_addr_t'(`SPM_POS_DEPTH / 2));

  // ------------------------------------------------------------------
  // busy, done and outer passes
  // ------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy        <= 1'b0;
      done        <= 1'b0;
      pass_next   <= 1'b0;
      pos_rd_addr <= '0;
    end
    else
    begin
      done      <= last_wr & (pos_rd_addr == pos_addr_t'(`SPM_POS_DEPTH - 1));
      pass_next <= last_wr & (pos_rd_addr != pos_addr_t'(`SPM_POS_DEPTH - 1));
      if (accept)
        busy <= 1'b1;
      else if (done)
        busy <= 1'b0;
      if (accept)
        pos_rd_addr <= '0;
      else if (pass_next)
        pos_rd_addr <= pos_rd_addr + 1'b1;
    end
  end

  // ------------------------------------------------------------------
  // strobes, addresses and the inner word counter
  // ------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pos_sr          <= '0;
      idx_sr          <= '0;
      wr_sr           <= '0;
      poly_rd_addr_0  <= '0;
      poly_rd_addr_1  <= '0;
      inner_cnt       <= '0;
      res_rd_addr_int <= '0;
      res_wr_addr     <= '0;
      res_wr_en       <= 1'b0;
    end
    else
    begin
      // position read, then dense fill plus previous-word stage, then datapath
      pos_sr <= {pos_sr[0], pass_go};
      idx_sr <= {idx_sr[0], pos_load};
      wr_sr  <= {wr_sr[2:0], idx_sr[1]};

      if (pos_load)
      begin
        poly_rd_addr_0 <= start_word(pos_rd_data[0 +: `SPM_POS_W]);
        poly_rd_addr_1 <= start_word(pos_rd_data[`SPM_POS_W +: `SPM_POS_W]);
      end
      else if (busy)
      begin
        poly_rd_addr_0 <= poly_rd_addr_0 + 1'b1;
        poly_rd_addr_1 <= poly_rd_addr_1 + 1'b1;
      end

      if (idx_sr[1])
        inner_cnt <= '0;
      else if (busy)
        inner_cnt <= inner_cnt + 1'b1;
      // stored result is needed one stage behind the core sum
      res_rd_addr_int <= inner_cnt;

      if (wr_sr[3])
        res_wr_en <= 1'b1;
      else if (last_wr)
        res_wr_en <= 1'b0;
      if (wr_sr[3])
        res_wr_addr <= '0;
      else if (res_wr_en)
        res_wr_addr <= res_wr_addr + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== spm_datapath.sv ====
// Sparse multiplier datapath
// rebuilds each core's coefficient pair from two dense words, applies the
// negacyclic sign, sums the cores mod Q and accumulates with the stored
// partial result

`timescale 1ns/100ps
`default_nettype none

`include "spm_params.svh"

module spm_datapath
  import spm_pkg::*;
(
  input  wire               clk,
  input  wire               rst_n,
  input  wire coeff_pair_t  poly_data_0,
  input  wire coeff_pair_t  poly_data_1,
  input  wire pos_word_t    pos_rd_data,
  input  wire               pos_load,
  input  wire coeff_idx_t   coeff_idx,
  input  wire               neg_pass,
  input  wire               first_pass,
  input  wire coeff_pair_t  res_rd_data,
  output coeff_pair_t       res_wr_data
);

  localparam int W = `SPM_COEFF_W;

  pos_t        pos_q     [`SPM_CORES];
  coeff_pair_t poly_cur  [`SPM_CORES];
  coeff_pair_t poly_prev [`SPM_CORES];
  coeff_pair_t pair      [`SPM_CORES];
  coeff_t      corr_lo   [`SPM_CORES];
  coeff_t      corr_hi   [`SPM_CORES];
  coeff_idx_t  idx_hi;
  coeff_sum_t  core_sum_lo;
  coeff_sum_t  core_sum_hi;
  coeff_t      sum_lo_q;
  coeff_t      sum_hi_q;
  coeff_t      res_lo;
  coeff_t      res_hi;
  coeff_sum_t  acc_lo_q;
  coeff_sum_t  acc_hi_q;

  // zero stays zero
  function automatic coeff_t neg_mod(input coeff_t a);
    return (a == '0) ? '0 : coeff_t'(`SPM_Q - a);
  endfunction

  // input is below 2Q
  function automatic coeff_t red_mod(input coeff_sum_t s);
    return (s >= coeff_sum_t'(`SPM_Q)) ? coeff_t'(s - coeff_sum_t'(`SPM_Q)) : coeff_t'(s);
  endfunction

  // wrap past x^N flips the sign, and so does a -1 position
  function automatic coeff_t sign_fix(input coeff_t a, input coeff_idx_t idx,
                                      input pos_t p, input logic neg);
    if ((idx >= p) ^ neg)
      return a;
    return neg_mod(a);
  endfunction

  assign poly_cur[0] = poly_data_0;
  assign poly_cur[1] = poly_data_1;
  assign idx_hi      = coeff_idx | coeff_idx_t'(1);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int c = 0; c < `SPM_CORES; c++)
        pos_q[c] <= '0;
    end
    else if (pos_load)
    begin
      for (int c = 0; c < `SPM_CORES; c++)
        pos_q[c] <= pos_rd_data[c*`SPM_POS_W +: `SPM_POS_W];
    end
  end

  // odd position straddles two words: high half of the older, low half of the newer
  always_comb
  begin
    for (int c = 0; c < `SPM_CORES; c++)
      pair[c] = pos_q[c][0] ? {poly_cur[c][W-1:0], poly_prev[c][2*W-1:W]} : poly_prev[c];
  end

  // ------------------------------------------------------------------
  // stage 1 sign correction, stage 2 core sum
  // ------------------------------------------------------------------
  assign core_sum_lo = coeff_sum_t'(corr_lo[0]) + coeff_sum_t'(corr_lo[1]);
  assign core_sum_hi = coeff_sum_t'(corr_hi[0]) + coeff_sum_t'(corr_hi[1]);

  always_ff @(posedge clk)
  begin
    for (int c = 0; c < `SPM_CORES; c++)
    begin
      poly_prev[c] <= poly_cur[c];
      corr_lo[c]   <= sign_fix(pair[c][W-1:0], coeff_idx, pos_q[c], neg_pass);
      corr_hi[c]   <= sign_fix(pair[c][2*W-1:W], idx_hi, pos_q[c], neg_pass);
    end
    sum_lo_q <= red_mod(core_sum_lo);
    sum_hi_q <= red_mod(core_sum_hi);
  end

  // ------------------------------------------------------------------
  // stage 3 accumulate, stage 4 final reduction
  // ------------------------------------------------------------------
  // result memory is not cleared, so the first pass ignores it
  assign res_lo = first_pass ? '0 : res_rd_data[W-1:0];
  assign res_hi = first_pass ? '0 : res_rd_data[2*W-1:W];

  always_ff @(posedge clk)
  begin
    acc_lo_q    <= coeff_sum_t'(sum_lo_q) + coeff_sum_t'(res_lo);
    acc_hi_q    <= coeff_sum_t'(sum_hi_q) + coeff_sum_t'(res_hi);
    res_wr_data <= {red_mod(acc_hi_q), red_mod(acc_lo_q)};
  end

endmodule

`default_nettype wire

// ==== spm_top.sv ====
// Sparse polynomial multiplier top level
// computes c = a*s mod (x^N+1, Q) for a dense a and a ternary sparse s;
// holds the dense, position and result memories and shares their ports
// between external load/read access and the running multiply

`timescale 1ns/100ps
`default_nettype none

`include "spm_params.svh"

module spm_top
  import spm_pkg::*;
(
  input  wire               clk,
  input  wire               rst_n,
  input  wire               start,
  output logic              busy,
  output logic              done,
  input  wire               poly_wr_en,
  input  wire word_addr_t   poly_wr_addr,
  input  wire coeff_pair_t  poly_wr_data,
  input  wire               pos_wr_en,
  input  wire pos_addr_t    pos_wr_addr,
  input  wire pos_word_t    pos_wr_data,
  input  wire               res_rd_en,
  input  wire word_addr_t   res_rd_addr,
  output coeff_pair_t       res_data
);

  pos_addr_t   pos_rd_addr;
  pos_word_t   pos_rd_data;
  word_addr_t  poly_rd_addr_0;
  word_addr_t  poly_rd_addr_1;
  word_addr_t  poly_addr_a;
  coeff_pair_t poly_data_0;
  coeff_pair_t poly_data_1;
  logic        pos_load;
  coeff_idx_t  coeff_idx;
  logic        neg_pass;
  logic        first_pass;
  word_addr_t  res_rd_addr_int;
  word_addr_t  res_addr_b;
  word_addr_t  res_wr_addr;
  logic        res_wr_en;
  coeff_pair_t res_wr_data;
  coeff_pair_t res_rd_data;
  logic        res_rd_q;

  // external access only happens while idle
  assign poly_addr_a = poly_wr_en ? poly_wr_addr : poly_rd_addr_0;
  assign res_addr_b  = res_rd_en ? res_rd_addr : res_rd_addr_int;

  // ------------------------------------------------------------------
  // memories
  // ------------------------------------------------------------------
  spm_dual_ram #(.WIDTH($bits(coeff_pair_t)), .DEPTH(`SPM_RES_DEPTH)) i_poly_ram (
    .clk       (clk),
    .wr_en_a   (poly_wr_en),
    .addr_a    (poly_addr_a),
    .wr_data_a (poly_wr_data),
    .rd_data_a (poly_data_0),
    .wr_en_b   (1'b0),
    .addr_b    (poly_rd_addr_1),
    .wr_data_b ('0),
    .rd_data_b (poly_data_1)
  );

  spm_dual_ram #(.WIDTH($bits(pos_word_t)), .DEPTH(`SPM_POS_DEPTH)) i_pos_ram (
    .clk       (clk),
    .wr_en_a   (pos_wr_en),
    .addr_a    (pos_wr_addr),
    .wr_data_a (pos_wr_data),
    .rd_data_a (),
    .wr_en_b   (1'b0),
    .addr_b    (pos_rd_addr),
    .wr_data_b ('0),
    .rd_data_b (pos_rd_data)
  );

  spm_dual_ram #(.WIDTH($bits(coeff_pair_t)), .DEPTH(`SPM_RES_DEPTH)) i_res_ram (
    .clk       (clk),
    .wr_en_a   (res_wr_en),
    .addr_a    (res_wr_addr),
    .wr_data_a (res_wr_data),
    .rd_data_a (),
    .wr_en_b   (1'b0),
    .addr_b    (res_addr_b),
    .wr_data_b ('0),
    .rd_data_b (res_rd_data)
  );

  // ------------------------------------------------------------------
  // control and datapath
  // ------------------------------------------------------------------
  spm_ctrl i_ctrl (
    .clk             (clk),
    .rst_n           (rst_n),
    .start           (start),
    .busy            (busy),
    .done            (done),
    .pos_rd_addr     (pos_rd_addr),
    .pos_rd_data     (pos_rd_data),
    .poly_rd_addr_0  (poly_rd_addr_0),
    .poly_rd_addr_1  (poly_rd_addr_1),
    .pos_load        (pos_load),
    .coeff_idx       (coeff_idx),
    .neg_pass        (neg_pass),
    .first_pass      (first_pass),
    .res_rd_addr_int (res_rd_addr_int),
    .res_wr_addr     (res_wr_addr),
    .res_wr_en       (res_wr_en)
  );

  spm_datapath i_datapath (
    .clk         (clk),
    .rst_n       (rst_n),
    .poly_data_0 (poly_data_0),
    .poly_data_1 (poly_data_1),
    .pos_rd_data (pos_rd_data),
    .pos_load    (pos_load),
    .coeff_idx   (coeff_idx),
    .neg_pass    (neg_pass),
    .first_pass  (first_pass),
    .res_rd_data (res_rd_data),
    .res_wr_data (res_wr_data)
  );

  // result read: RAM cycle, then the output register
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      res_rd_q <= 1'b0;
    else
      res_rd_q <= res_rd_en;
  end

  always_ff @(posedge clk)
  begin
    if (res_rd_q)
      res_data <= res_rd_data;
  end

endmodule

`default_nettype wire

// ==== spm_properties.sv ====
// Control timing checks for the sparse multiplier
// done and busy sequencing, result writes and ignored start pulses

`timescale 1ns/100ps
`default_nettype none

module spm_properties
  import spm_pkg::*;
(
  input wire            clk,
  input wire            rst_n,
  input wire            start,
  input wire            busy,
  input wire            done,
  input wire            res_wr_en,
  input wire            pass_next,
  input wire pos_addr_t pos_rd_addr
);

  // number of failed properties, read by the testbench at the end
  int fail_count = 0;

  // done is a single-cycle pulse
  done_single: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
    else
    begin
      $error("done held high for more than one cycle");
      fail_count++;
    end

  busy_after_done: assert property (@(posedge clk) disable iff (!rst_n) done |=> !busy)
    else
    begin
      $error("busy still high the cycle after done");
      fail_count++;
    end

  wr_in_busy: assert property (@(posedge clk) disable iff (!rst_n) res_wr_en |-> busy)
    else
    begin
      $error("result write outside a run");
      fail_count++;
    end

  // a start pulse in the middle of a run leaves the pass counter alone
  start_ignored: assert property (@(posedge clk) disable iff (!rst_n)
    (start && busy && !pass_next) |=> (pos_rd_addr == $past(pos_rd_addr)))
    else
    begin
      $error("start while busy moved the pass counter");
      fail_count++;
    end

endmodule

bind spm_ctrl spm_properties i_props (
  .clk         (clk),
  .rst_n       (rst_n),
  .start       (start),
  .busy        (busy),
  .done        (done),
  .res_wr_en   (res_wr_en),
  .pass_next   (pass_next),
  .pos_rd_addr (pos_rd_addr)
);

`default_nettype wire

// ==== tb_spm.sv ====
// Testbench for the sparse polynomial multiplier
// loads random dense and sparse operands, runs the multiply and compares
// every result word with a reference model of c = a*s mod (x^N+1, Q)

`timescale 1ns/100ps
`default_nettype none

`include "spm_params.svh"

module tb_spm
  import spm_pkg::*;
();

  localparam int Q             = `SPM_Q;
  localparam int N             = `SPM_N;
  localparam int H             = `SPM_H;
  localparam int DEPTH         = `SPM_RES_DEPTH;
  localparam int POS_DEPTH     = `SPM_POS_DEPTH;
  localparam int RUN_TIMEOUT   = 2000;
  localparam int READ_TIMEOUT  = 500;

  logic        clk          = 1'b0;
  logic        rst_n        = 1'b0;
  logic        start        = 1'b0;
  logic        busy;
  logic        done;
  logic        poly_wr_en   = 1'b0;
  word_addr_t  poly_wr_addr = '0;
  coeff_pair_t poly_wr_data = '0;
  logic        pos_wr_en    = 1'b0;
  pos_addr_t   pos_wr_addr  = '0;
  pos_word_t   pos_wr_data  = '0;
  logic        res_rd_en    = 1'b0;
  word_addr_t  res_rd_addr  = '0;
  coeff_pair_t res_data;

  integer seed       = 85;
  int     errors     = 0;
  int     checks     = 0;
  int     prop_fails = 0;
  int     a_coef [N];
  int     pos    [H];
  int     model  [N];

  always #2 clk = ~clk;

  spm_top i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .start        (start),
    .busy         (busy),
    .done         (done),
    .poly_wr_en   (poly_wr_en),
    .poly_wr_addr (poly_wr_addr),
    .poly_wr_data (poly_wr_data),
    .pos_wr_en    (pos_wr_en),
    .pos_wr_addr  (pos_wr_addr),
    .pos_wr_data  (pos_wr_data),
    .res_rd_en    (res_rd_en),
    .res_rd_addr  (res_rd_addr),
    .res_data     (res_data)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $finish;
  endtask

  // ------------------------------------------------------------------
  // operands and reference model
  // ------------------------------------------------------------------
  task automatic make_random_operands();
    int perm [N];
    int j;
    int tmp;
    for (int i = 0; i < N; i++)
      a_coef[i] = $unsigned($random(seed)) % Q;
    for (int i = 0; i < N; i++)
      perm[i] = i;
    // shuffle and take the first H as distinct positions
    for (int i = N - 1; i > 0; i--)
    begin
      j = $unsigned($random(seed)) % (i + 1);
      tmp = perm[i];
      perm[i] = perm[j];
      perm[j] = tmp;
    end
    for (int i = 0; i < H; i++)
      pos[i] = perm[i];
  endtask

  // matching +1/-1 pairs cancel and leave a minus a shifted by N/2
  task automatic make_cancel_operands();
    for (int i = 0; i < N; i++)
      a_coef[i] = $unsigned($random(seed)) % Q;
    pos[0] = 0;
    for (int i = 1; i < H / 2; i++)
    begin
      pos[i] = i;
      pos[i + H / 2 - 1] = i;
    end
    pos[H - 1] = N / 2;
  endtask

  task automatic compute_model();
    int idx;
    int v;
    for (int k = 0; k < N; k++)
    begin
      model[k] = 0;
      for (int i = 0; i < H; i++)
      begin
        idx = k - pos[i];
        // x^N = -1 flips the sign of a wrapped term
        if (idx >= 0)
          v = a_coef[idx];
        else
          v = (Q - a_coef[idx + N]) % Q;
        if (i >= H / 2)
          v = (Q - v) % Q;
        model[k] = (model[k] + v) % Q;
      end
    end
  endtask

  // ------------------------------------------------------------------
  // loading, running and checking
  // ------------------------------------------------------------------
  task automatic load_memories();
    for (int w = 0; w < DEPTH; w++)
    begin
      @(posedge clk);
      poly_wr_en   <= 1'b1;
      poly_wr_addr <= word_addr_t'(w);
      poly_wr_data <= {coeff_t'(a_coef[2*w+1]), coeff_t'(a_coef[2*w])};
    end
    for (int w = 0; w < POS_DEPTH; w++)
    begin
      @(posedge clk);
      poly_wr_en  <= 1'b0;
      pos_wr_en   <= 1'b1;
      pos_wr_addr <= pos_addr_t'(w);
      pos_wr_data <= {pos_t'(pos[2*w+1]), pos_t'(pos[2*w])};
    end
    @(posedge clk);
    pos_wr_en <= 1'b0;
  endtask

  // stray_at > 0 pulses start again at that cycle of the run
  task automatic run_mult(input string name, input int stray_at);
    int cyc;
    int dones;
    cyc = 0;
    dones = 0;
    do
    begin
      @(posedge clk);
      start <= (cyc == 0) || (cyc == stray_at);
      @(negedge clk);
      if (done)
        dones++;
      // busy follows the accepted start by one cycle
      if (cyc == 1)
      begin
        checks++;
        assert (busy)
        else
        begin
          errors++;
          $display("** Error %s: busy after start expected 1 actual %b", name, busy);
        end
      end
      cyc++;
      if (cyc > RUN_TIMEOUT)
        abort_run($sformatf("timeout in %s: no done within %0d cycles", name, RUN_TIMEOUT));
    end
    while (busy || cyc < 2);
    @(posedge clk);
    start <= 1'b0;
    checks++;
    assert (dones == 1)
    else
    begin
      errors++;
      $display("** Error %s: expected 1 done pulse, actual %0d", name, dones);
    end
  endtask

  // reads all words with random gaps and checks each 2 cycles after its request
  task automatic check_results(input string name);
    int due_q [$];
    int addr_q [$];
    int next;
    int cyc;
    int w;
    coeff_pair_t exp;
    next = 0;
    cyc = 0;
    while (next < DEPTH || due_q.size() > 0)
    begin
      @(posedge clk);
      if (next < DEPTH && ($random(seed) & 3) != 0)
      begin
        res_rd_en   <= 1'b1;
        res_rd_addr <= word_addr_t'(next);
        due_q.push_back(cyc + 2);
        addr_q.push_back(next);
        next++;
      end
      else
        res_rd_en <= 1'b0;
      @(negedge clk);
      if (due_q.size() > 0 && due_q[0] == cyc)
      begin
        w = addr_q.pop_front();
        void'(due_q.pop_front());
        exp = {coeff_t'(model[2*w+1]), coeff_t'(model[2*w])};
        checks++;
        assert (res_data == exp)
        else
        begin
          errors++;
          $display("** Error %s: word %0d expected %h actual %h", name, w, exp, res_data);
        end
      end
      cyc++;
      if (cyc > READ_TIMEOUT)
        abort_run($sformatf("timeout in %s: result reads did not finish", name));
    end
  endtask

  // ------------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------------
  initial
  begin
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    checks++;
    assert (!busy && !done)
    else
    begin
      errors++;
      $display("** Error reset_idle: expected busy=0 done=0 actual busy=%b done=%b", busy, done);
    end

    for (int r = 0; r < 3; r++)
    begin
      make_random_operands();
      compute_model();
      load_memories();
      run_mult("random", -1);
      check_results("random");
    end

    // rerun on the same memories with stale results left in the result RAM
    run_mult("rerun", -1);
    check_results("rerun");
    run_mult("stray_start", 40);
    check_results("stray_start");

    make_cancel_operands();
    compute_model();
    load_memories();
    run_mult("cancel_pattern", -1);
    check_results("cancel_pattern");

    prop_fails = i_dut.i_ctrl.i_props.fail_count;
    $display("checks: %0d  errors: %0d  property failures: %0d", checks, errors, prop_fails);
    if (errors == 0 && prop_fails == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+.
spm_pkg.sv
spm_dual_ram.sv
spm_ctrl.sv
spm_datapath.sv
spm_top.sv
spm_properties.sv
tb_spm.sv

// ==== Makefile ====
# Verilator build, run and lint for the sparse polynomial multiplier

VERILATOR ?= verilator
TOP       ?= tb_spm
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "SIMULATION PASSED" $(LOG); then \
	  echo "run passed"; \
	else \
	  echo "run failed, see $(LOG)"; \
	  exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
